/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

	localparam int instrWidth = 32;

	typedef enum logic [6:0] {
		opR      = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opLui    = 7'b0110111,
		opSystem = 7'b1110011
	} opcodeT;

	// standard RISC-V field layout, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeT     opcode;
	} instrFieldsT;

	localparam logic [instrWidth-1:0] nopWord = 32'h0000_0013; // addi x0,x0,0

	// funct3 codes
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Srx    = 3'b101; // srli / srai, split by funct7[5]
	localparam logic [2:0] f3And    = 3'b111;
	localparam logic [2:0] f3Beq    = 3'b000;
	localparam logic [2:0] f3Bne    = 3'b001;
	localparam logic [2:0] f3Blt    = 3'b100;
	localparam logic [2:0] f3Bge    = 3'b101;
	localparam logic [2:0] f3Priv   = 3'b000; // ebreak lives here

	typedef enum logic [4:0] {
		clsAdd, clsSub, clsAnd, clsSlt,
		clsAddi, clsSlti, clsSrli, clsSrai, clsSlli,
		clsLoad, clsStore,
		clsBeq, clsBne, clsBge, clsBlt,
		clsJal, clsJalr, clsLui,
		clsBreak,
		clsNop,
		clsIgnore,  // known opcode, unsupported funct
		clsIllegal  // unknown opcode
	} opClassT;

endpackage

`default_nettype wire

/* verilog/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

	typedef enum logic [4:0] {
		stStart, stFetch, stDecode,
		stAddrCalc, stMemWait, stLoadWb, stStoreWr,
		stExeAdd, stExeSub, stExeAnd, stAluWb,
		stExeSlt, stExeSlti,
		stShiftRl, stShiftRa, stShiftLl,
		stLui,
		stBeq, stBne, stBge, stBlt,
		stJal, stJalrCalc, stJalrJump,
		stHalt
	} stateT;

	typedef enum logic [1:0] {
		shNone         = 2'b00,
		shRightLogical = 2'b01,
		shRightArith   = 2'b10,
		shLeft         = 2'b11
	} shiftOpT;

	typedef enum logic [2:0] {
		mtrAluOut   = 3'b000,
		mtrMdr      = 3'b001,
		mtrLessThan = 3'b010,
		mtrShifter  = 3'b011,
		mtrPc       = 3'b100,
		mtrUpperImm = 3'b101
	} memToRegT;

	typedef enum logic [1:0] {
		srcAPc   = 2'b00,
		srcARegA = 2'b01
	} aluSrcAT;

	typedef enum logic [1:0] {
		srcBRegB      = 2'b00,
		srcBFour      = 2'b01,
		srcBImm       = 2'b10,
		srcBBranchOff = 2'b11
	} aluSrcBT;

	typedef enum logic [2:0] {
		aluPass    = 3'b000,
		aluAdd     = 3'b001,
		aluSub     = 3'b010,
		aluAnd     = 3'b011,
		aluCompare = 3'b111
	} aluFctT;

	typedef enum logic [2:0] {
		brNone = 3'b000,
		brEq   = 3'b001,
		brNe   = 3'b010,
		brGe   = 3'b011,
		brLt   = 3'b100
	} branchCondT;

	typedef struct packed {
		shiftOpT    shiftOp;
		logic       regWrite;
		logic       memWrite;
		logic       loadIR;
		memToRegT   memToReg;
		aluSrcAT    aluSrcA;
		aluSrcBT    aluSrcB;
		aluFctT     aluFct;
		logic       pcWrite;
		branchCondT branchCond; // conditional pc write when not none
		logic       pcSource;
		logic       loadRegA;
		logic       loadRegB;
		logic       loadAOut;
		logic       loadMDR;
	} ctrlWordT;

	localparam ctrlWordT idleWord = '{
		shiftOp:    shNone,
		regWrite:   1'b0,
		memWrite:   1'b0,
		loadIR:     1'b0,
		memToReg:   mtrAluOut,
		aluSrcA:    srcAPc,
		aluSrcB:    srcBRegB,
		aluFct:     aluPass,
		pcWrite:    1'b0,
		branchCond: brNone,
		pcSource:   1'b0,
		loadRegA:   1'b0,
		loadRegB:   1'b0,
		loadAOut:   1'b0,
		loadMDR:    1'b0
	};

endpackage

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import isaPkg::*; (
	input  logic [instrWidth-1:0] instr,
	output opClassT               opClass
);

	instrFieldsT fields;
	logic        alt; // funct7[5], selects sub / srai

	assign fields = instrFieldsT'(instr);
	assign alt    = fields.funct7[5];

	always_comb begin
		opClass = clsIgnore;
		if (instr == nopWord) begin
			opClass = clsNop;
		end else begin
			case (fields.opcode)
				opR: begin
					case (fields.funct3)
						f3AddSub: opClass = alt ? clsSub : clsAdd;
						f3Slt:    opClass = alt ? clsIgnore : clsSlt;
						f3And:    opClass = alt ? clsIgnore : clsAnd;
						default:  opClass = clsIgnore;
					endcase
				end
				opImm: begin
					case (fields.funct3)
						f3AddSub: opClass = clsAddi;
						f3Slt:    opClass = clsSlti;
						f3Sll:    opClass = clsSlli;
						f3Srx:    opClass = alt ? clsSrai : clsSrli;
						default:  opClass = clsIgnore;
					endcase
				end
				opLoad: begin
					opClass = clsLoad; // width handled by datapath
				end
				opStore: begin
					opClass = clsStore;
				end
				opBranch: begin
					case (fields.funct3)
						f3Beq:   opClass = clsBeq;
						f3Bne:   opClass = clsBne;
						f3Blt:   opClass = clsBlt;
						f3Bge:   opClass = clsBge;
						default: opClass = clsIgnore;
					endcase
				end
				opJal: begin
					opClass = clsJal;
				end
				opJalr: begin
					opClass = (fields.funct3 == 3'b000) ? clsJalr : clsIgnore;
				end
				opLui: begin
					opClass = clsLui;
				end
				opSystem: begin
					opClass = (fields.funct3 == f3Priv) ? clsBreak : clsIgnore;
				end
				default: begin
					opClass = clsIllegal;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/ctrlSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlSequencer import isaPkg::*, ctrlPkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  opClassT opClass,
	output stateT   state
);

	stateT nextState;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= stStart;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = stStart;
		case (state)
			stStart:  nextState = stFetch;
			stFetch:  nextState = stDecode;
			stDecode: begin
				case (opClass)
					clsAdd:                        nextState = stExeAdd;
					clsSub:                        nextState = stExeSub;
					clsAnd:                        nextState = stExeAnd;
					clsSlt:                        nextState = stExeSlt;
					clsSlti:                       nextState = stExeSlti;
					clsSrli:                       nextState = stShiftRl;
					clsSrai:                       nextState = stShiftRa;
					clsSlli:                       nextState = stShiftLl;
					clsAddi, clsLoad, clsStore:    nextState = stAddrCalc;
					clsBeq:                        nextState = stBeq;
					clsBne:                        nextState = stBne;
					clsBge:                        nextState = stBge;
					clsBlt:                        nextState = stBlt;
					clsJal:                        nextState = stJal;
					clsJalr:                       nextState = stJalrCalc;
					clsLui:                        nextState = stLui;
					clsBreak, clsIllegal:          nextState = stHalt;
					default:                       nextState = stStart; // nop, ignore
				endcase
			end
			stAddrCalc: begin
				if (opClass == clsLoad || opClass == clsStore) begin
					nextState = stMemWait;
				end else if (opClass == clsAddi) begin
					nextState = stAluWb;
				end else begin
					nextState = stStart;
				end
			end
			stMemWait: begin
				if (opClass == clsLoad) begin
					nextState = stLoadWb;
				end else if (opClass == clsStore) begin
					nextState = stStoreWr;
				end else begin
					nextState = stStart;
				end
			end
			stExeAdd, stExeSub, stExeAnd: nextState = stAluWb;
			stJalrCalc:                   nextState = stJalrJump;
			stHalt:                       nextState = stHalt; // only reset leaves
			default:                      nextState = stStart;
		endcase
	end

	haltAbsorbing: assert property (
		@(posedge clk) disable iff (reset)
		state == stHalt |=> state == stHalt
	) else $error("left stHalt without reset");

	noRefetchAfterDecode: assert property (
		@(posedge clk) disable iff (reset)
		state == stDecode |=> state != stFetch
	) else $error("stFetch directly after stDecode");

endmodule

`default_nettype wire

/* verilog/ctrlWordGen.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlWordGen import ctrlPkg::*; (
	input  stateT    state,
	output ctrlWordT ctrlWord
);

	always_comb begin
		ctrlWord = idleWord;
		case (state)
			stFetch: begin
				ctrlWord.loadIR  = 1'b1;
				ctrlWord.aluSrcB = srcBFour; // pc + 4
				ctrlWord.aluFct  = aluAdd;
				ctrlWord.pcWrite = 1'b1;
			end
			stDecode: begin
				ctrlWord.loadIR   = 1'b1;
				ctrlWord.aluSrcB  = srcBBranchOff; // precompute branch target
				ctrlWord.aluFct   = aluAdd;
				ctrlWord.loadRegA = 1'b1;
				ctrlWord.loadRegB = 1'b1;
				ctrlWord.loadAOut = 1'b1;
			end
			stAddrCalc, stJalrCalc: begin
				ctrlWord.aluSrcA  = srcARegA;
				ctrlWord.aluSrcB  = srcBImm;
				ctrlWord.aluFct   = aluAdd;
				ctrlWord.loadAOut = 1'b1;
			end
			stLoadWb: begin
				ctrlWord.regWrite = 1'b1;
				ctrlWord.memToReg = mtrMdr;
				ctrlWord.loadMDR  = 1'b1;
			end
			stStoreWr: begin
				ctrlWord.memWrite = 1'b1;
			end
			stExeAdd, stExeSub, stExeAnd: begin
				ctrlWord.aluSrcA  = srcARegA;
				ctrlWord.aluSrcB  = srcBRegB;
				ctrlWord.loadAOut = 1'b1;
				ctrlWord.aluFct   = (state == stExeAdd) ? aluAdd :
				                    (state == stExeSub) ? aluSub : aluAnd;
			end
			stAluWb: begin
				ctrlWord.regWrite = 1'b1;
				ctrlWord.memToReg = mtrAluOut;
			end
			stExeSlt, stExeSlti: begin
				ctrlWord.aluSrcA  = srcARegA;
				ctrlWord.aluSrcB  = (state == stExeSlti) ? srcBImm : srcBRegB;
				ctrlWord.aluFct   = aluCompare;
				ctrlWord.regWrite = 1'b1;
				ctrlWord.memToReg = mtrLessThan;
			end
			stShiftRl, stShiftRa, stShiftLl: begin
				ctrlWord.regWrite = 1'b1;
				ctrlWord.memToReg = mtrShifter;
				ctrlWord.shiftOp  = (state == stShiftRl) ? shRightLogical :
				                    (state == stShiftRa) ? shRightArith : shLeft;
			end
			stLui: begin
				ctrlWord.regWrite = 1'b1;
				ctrlWord.memToReg = mtrUpperImm;
			end
			stBeq, stBne, stBge, stBlt: begin
				ctrlWord.aluSrcA  = srcARegA;
				ctrlWord.aluSrcB  = srcBRegB;
				ctrlWord.pcSource = 1'b1; // target sits in aOut
				ctrlWord.aluFct   = (state == stBeq || state == stBne) ? aluSub : aluCompare;
				case (state)
					stBeq:   ctrlWord.branchCond = brEq;
					stBne:   ctrlWord.branchCond = brNe;
					stBge:   ctrlWord.branchCond = brGe;
					default: ctrlWord.branchCond = brLt;
				endcase
			end
			stJal, stJalrJump: begin
				ctrlWord.regWrite = 1'b1;
				ctrlWord.memToReg = mtrPc; // link address
				ctrlWord.pcWrite  = 1'b1;
				ctrlWord.pcSource = 1'b1;
			end
			default: ctrlWord = idleWord; // start, mem wait, halt
		endcase
	end

	// register file and memory never written in the same state
	always_comb begin
		assert (!(ctrlWord.regWrite && ctrlWord.memWrite))
			else $error("regWrite and memWrite both set in state %0d", state);
		assert (!(ctrlWord.pcWrite && ctrlWord.branchCond != brNone))
			else $error("unconditional and conditional pc write in state %0d", state);
	end

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import isaPkg::*, ctrlPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [instrWidth-1:0] instr,
	output stateT                 stateOut,
	output ctrlWordT              ctrl
);

	opClassT opClass;

	instrDecoder decoder0 (
		.instr   (instr),
		.opClass (opClass)
	);

	ctrlSequencer sequencer0 (
		.clk     (clk),
		.reset   (reset),
		.opClass (opClass),
		.state   (stateOut)
	);

	ctrlWordGen wordGen0 (
		.state    (stateOut),
		.ctrlWord (ctrl)
	);

endmodule

`default_nettype wire

/* tb/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

endmodule

`default_nettype wire

/* tb/controlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb import isaPkg::*, ctrlPkg::*;;

	localparam int maxRecords = 64;

	logic                  clk;
	logic                  reset;
	logic [instrWidth-1:0] instr;
	stateT                 stateOut;
	ctrlWordT              ctrl;

	int seed = 32'he2b3;
	int cycleCount = 0;
	int cycleLimit = 64;

	logic [31:0] recInstr [maxRecords];
	int          recLen [maxRecords];
	logic [4:0]  recPath [maxRecords][6];
	logic [23:0] recCtrl [maxRecords];
	logic        recHalt [maxRecords];
	int          recCount = 0;

	ctrlWordT fetchWord;
	ctrlWordT decodeWord;

	clockGen clk0 (.clk(clk));

	controlUnit dut0 (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.stateOut (stateOut),
		.ctrl     (ctrl)
	);

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic stopOnFileError(input string what);
		$display("golden file problem: %s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic readGolden();
		int          fd;
		int          n;
		int          len;
		int          halt;
		string       line;
		logic [31:0] word;
		logic [31:0] ctrlVal;
		logic [7:0]  s0, s1, s2, s3, s4, s5;
		fd = $fopen("tb/golden_vectors.txt", "r");
		if (fd == 0) stopOnFileError("cannot open tb/golden_vectors.txt");
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %d %h %h %h %h %h %h %h %d",
					word, len, s0, s1, s2, s3, s4, s5, ctrlVal, halt);
				if (n != 10) stopOnFileError($sformatf("malformed record: %s", line));
				if (len < 3 || len > 6) stopOnFileError("path length outside 3 to 6");
				if (halt != 0 && halt != 1) stopOnFileError("halt flag is not 0 or 1");
				if (recCount >= maxRecords) stopOnFileError("too many records");
				recInstr[recCount]   = word;
				recLen[recCount]     = len;
				recPath[recCount][0] = s0[4:0];
				recPath[recCount][1] = s1[4:0];
				recPath[recCount][2] = s2[4:0];
				recPath[recCount][3] = s3[4:0];
				recPath[recCount][4] = s4[4:0];
				recPath[recCount][5] = s5[4:0];
				recCtrl[recCount]    = ctrlVal[23:0];
				recHalt[recCount]    = halt[0];
				recCount++;
			end
		end
		$fclose(fd);
		if (recCount == 0) stopOnFileError("no records found");
	endtask

	// state of the path plus the store-only memWrite rule
	task automatic checkStep(input int r, input int i);
		checkVal("stateOut", 32'(stateOut), 32'(recPath[r][i]));
		checkVal("ctrl.memWrite", 32'(ctrl.memWrite), 32'(recPath[r][i] == stStoreWr));
	endtask

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		instr <= $random(seed);
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
	endtask

	task automatic runRecord(input int r);
		int i;
		checkStep(r, 0);
		@(posedge clk);
		instr <= $random(seed); // noise during fetch
		@(negedge clk);
		checkStep(r, 1);
		@(posedge clk);
		instr <= recInstr[r]; // held from decode on
		@(negedge clk);
		checkStep(r, 2);
		for (i = 3; i < recLen[r]; i++) begin
			@(posedge clk);
			@(negedge clk);
			checkStep(r, i);
		end
		checkVal("ctrl", 32'(ctrl), {8'h00, recCtrl[r]});
		if (recHalt[r]) begin
			repeat (16) begin
				@(posedge clk);
				@(negedge clk);
				checkVal("stateOut", 32'(stateOut), 32'(stHalt));
				checkVal("ctrl", 32'(ctrl), 32'(idleWord));
			end
			applyReset();
		end else begin
			@(posedge clk);
			instr <= $random(seed);
			@(negedge clk);
		end
		checkVal("stateOut", 32'(stateOut), 32'(stStart));
		checkVal("ctrl", 32'(ctrl), 32'(idleWord));
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	initial begin
		reset = 1'b1;
		instr = '0;
		fetchWord = idleWord;
		fetchWord.loadIR = 1'b1;
		fetchWord.aluSrcB = srcBFour;
		fetchWord.aluFct = aluAdd;
		fetchWord.pcWrite = 1'b1;
		decodeWord = idleWord;
		decodeWord.loadIR = 1'b1;
		decodeWord.aluSrcB = srcBBranchOff;
		decodeWord.aluFct = aluAdd;
		decodeWord.loadRegA = 1'b1;
		decodeWord.loadRegB = 1'b1;
		decodeWord.loadAOut = 1'b1;
		readGolden();
		cycleLimit = recCount * 8 + 64;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		instr <= $random(seed);
		@(negedge clk);
		checkVal("stateOut", 32'(stateOut), 32'(stStart));
		checkVal("ctrl", 32'(ctrl), 32'(idleWord));
		@(posedge clk);
		instr <= $random(seed);
		@(negedge clk);
		checkVal("stateOut", 32'(stateOut), 32'(stFetch));
		checkVal("ctrl", 32'(ctrl), 32'(fetchWord));
		@(posedge clk);
		instr <= nopWord; // sends the FSM straight back to start
		@(negedge clk);
		checkVal("stateOut", 32'(stateOut), 32'(stDecode));
		checkVal("ctrl", 32'(ctrl), 32'(decodeWord));
		@(posedge clk);
		instr <= $random(seed);
		@(negedge clk);
		checkVal("stateOut", 32'(stateOut), 32'(stStart));
		for (int r = 0; r < recCount; r++) begin
			runRecord(r);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/golden_vectors.txt */
# instr len s0 s1 s2 s3 s4 s5 ctrl halt (all hex except len and halt)
# states from stStart to the last one before the return, unused slots 00, ctrl of the last state
002081b3 5 00 01 02 07 0a 00 200000 0
402081b3 5 00 01 02 08 0a 00 200000 0
0020f1b3 5 00 01 02 09 0a 00 200000 0
0020a1b3 4 00 01 02 0b 00 00 224e00 0
00508193 5 00 01 02 03 0a 00 200000 0
0050a193 4 00 01 02 0c 00 00 226e00 0
0040d193 4 00 01 02 0d 00 00 630000 0
4040d193 4 00 01 02 0e 00 00 a30000 0
00409193 4 00 01 02 0f 00 00 e30000 0
123451b7 4 00 01 02 10 00 00 250000 0
00208463 4 00 01 02 11 00 00 004430 0
00209463 4 00 01 02 12 00 00 004450 0
0020d463 4 00 01 02 13 00 00 004e70 0
0020c463 4 00 01 02 14 00 00 004e90 0
010000ef 4 00 01 02 15 00 00 240110 0
000280e7 5 00 01 02 16 17 00 240110 0
0080a183 6 00 01 02 03 04 05 210001 0
0020a423 6 00 01 02 03 04 06 100000 0
00000013 3 00 01 02 00 00 00 08320e 0
0050b193 3 00 01 02 00 00 00 08320e 0
00100073 4 00 01 02 18 00 00 000000 1
002081b3 5 00 01 02 07 0a 00 200000 0
0000000b 4 00 01 02 18 00 00 000000 1
0080a183 6 00 01 02 03 04 05 210001 0

/* verilog.f */
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/ctrlSequencer.sv
verilog/ctrlWordGen.sv
verilog/controlUnit.sv
tb/clockGen.sv
tb/controlUnitTb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module controlUnitTb \
		-f verilog.f -o controlUnitSim

run: compile
	./obj_dir/controlUnitSim

clean:
	rm -rf obj_dir
